// File: Makefile
# Verilator build and run of the soc_core testbench
TOP := soc_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing --assert -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: common/soc_cfg.svh
// Build-time constants; RAM wraps above 2**SOC_RAM_AW words and tick period is 2**RES/PHASE
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// On-chip RAM word-address bits
`define SOC_RAM_AW 10

// Timer accumulator width and the step added every clock
`define SOC_TIMER_RES 8
`define SOC_TIMER_PHASE 16

// LED port answers anywhere in this I/O page (byte address bits 15:8)
`define SOC_IO_LED_PAGE 8'hF1

// Switch port, byte address 0102h
`define SOC_IO_SW_ADR 15'h0081

// Keyboard status port, byte address 0064h
`define SOC_IO_STAT_ADR 15'h0032

// Status word seen by software polling the keyboard controller
`define SOC_STAT_WORD 16'h0010

// Interrupt vector base, vector is base plus iid
`define SOC_VEC_BASE 8'h08

`endif

// File: common/soc_pkg.sv
// Bus and interrupt types shared by every block; 16-bit data, 20-bit byte address space
`default_nettype none

package soc_pkg;

  // Word address, byte address bits 19:1
  typedef logic [19:1] bus_adr_t;

  typedef logic [15:0] bus_dat_t;

  // Bit 0 selects the low byte
  typedef logic [1:0]  bus_sel_t;

  // One request line per interrupt source
  typedef logic [7:0]  irq_vec_t;

  // Index of the interrupt being served
  typedef logic [2:0]  iid_t;

  // Master cycle, tga high selects I/O space
  typedef struct packed {
    bus_adr_t adr;
    bus_dat_t dat;
    logic     we;
    logic     tga;
    bus_sel_t sel;
    logic     stb;
    logic     cyc;
  } bus_req_t;

  typedef struct packed {
    bus_dat_t dat;
    logic     ack;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: filelist.f
+incdir+common
common/soc_pkg.sv
hdl/pit_timer.sv
hdl/pic_simple.sv
hdl/ram_slave.sv
hdl/io_decoder.sv
hdl/soc_core.sv
tests/soc_core_props.sv
tests/soc_core_tb.sv

// File: hdl/io_decoder.sv
// Single master only; all I/O is acked combinationally, LED port is write-only and reads FFFFh
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module io_decoder (
  input  logic              clk,
  input  logic              arst_n_i,
  input  soc_pkg::bus_req_t bus_i,
  output soc_pkg::bus_rsp_t bus_o,
  output soc_pkg::bus_req_t mem_req_o,
  input  soc_pkg::bus_rsp_t mem_rsp_i,
  input  logic              inta_i,
  input  soc_pkg::iid_t     iid_i,
  input  logic [7:0]        sw_i,
  output soc_pkg::bus_dat_t led_o
);

  logic              bus_act;
  logic              io_cyc;
  logic              mem_space;
  logic              led_arena;
  logic              sw_arena;
  logic              stat_arena;
  logic              led_wr;
  logic [7:0]        vec;
  soc_pkg::bus_dat_t io_dat;
  soc_pkg::bus_dat_t led_q;

  assign bus_act = bus_i.stb & bus_i.cyc;

  // Interrupt acknowledge cycles never reach a slave
  assign mem_space = ~bus_i.tga & ~inta_i;
  assign io_cyc    = bus_act & bus_i.tga & ~inta_i;

  // I/O decode on the 16-bit port address
  assign led_arena  = (bus_i.adr[15:8] == `SOC_IO_LED_PAGE);
  assign sw_arena   = (bus_i.adr[15:1] == `SOC_IO_SW_ADR);
  assign stat_arena = (bus_i.adr[15:1] == `SOC_IO_STAT_ADR);

  // RAM sees the cycle with its strobe gated by memory space
  always_comb begin
    mem_req_o     = bus_i;
    mem_req_o.stb = bus_i.stb & mem_space;
  end

  // Read data of the I/O ports, anything unmapped floats high
  always_comb begin
    if (sw_arena) begin
      io_dat = {8'h00, sw_i};
    end else if (stat_arena) begin
      io_dat = `SOC_STAT_WORD;
    end else begin
      io_dat = 16'hFFFF;
    end
  end

  assign vec = `SOC_VEC_BASE + 8'(iid_i);

  // Vector first, then I/O, then RAM
  always_comb begin
    if (inta_i) begin
      bus_o.dat = {8'h00, vec};
      bus_o.ack = bus_act;
    end else if (bus_i.tga) begin
      bus_o.dat = io_dat;
      bus_o.ack = bus_act;
    end else begin
      bus_o.dat = mem_rsp_i.dat;
      bus_o.ack = mem_rsp_i.ack;
    end
  end

  // LED write lands on the edge that closes the acked cycle
  assign led_wr = io_cyc & bus_i.we & led_arena;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      led_q <= '0;
    end else if (led_wr) begin
      if (bus_i.sel[0]) begin
        led_q[7:0] <= bus_i.dat[7:0];
      end
      if (bus_i.sel[1]) begin
        led_q[15:8] <= bus_i.dat[15:8];
      end
    end
  end

  assign led_o = led_q;

endmodule

`default_nettype wire

// File: hdl/pic_simple.sv
// Edge-triggered, fixed priority with line 0 highest; pending clears once per inta_i rising cycle
`timescale 1ns/100ps
`default_nettype none

module pic_simple (
  input  logic              clk,
  input  logic              arst_n_i,
  input  soc_pkg::irq_vec_t intv_i,
  input  logic              inta_i,
  output logic              intr_o,
  output soc_pkg::iid_t     iid_o
);

  localparam int N = $bits(soc_pkg::irq_vec_t);

  soc_pkg::irq_vec_t intv_q;
  soc_pkg::irq_vec_t rise;
  soc_pkg::irq_vec_t pending;
  soc_pkg::irq_vec_t clr;
  logic              inta_q;
  soc_pkg::iid_t     iid;

  assign rise = intv_i & ~intv_q;

  // Lowest pending index wins, so scan from the top down
  always_comb begin
    iid = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid = soc_pkg::iid_t'(i);
      end
    end
  end

  // Served line drops at the end of the acknowledge cycle
  always_comb begin
    clr = '0;
    if (inta_i && !inta_q) begin
      clr[iid] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      intv_q  <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
    end else begin
      intv_q  <= intv_i;
      inta_q  <= inta_i;
      // A fresh edge beats a clear on the same line
      pending <= (pending & ~clr) | rise;
    end
  end

  assign intr_o = |pending;
  assign iid_o  = iid;

endmodule

`default_nettype wire

// File: hdl/pit_timer.sv
// Free-running, no bus access; tick period is 2**RES/PHASE cycles only when PHASE divides 2**RES
`timescale 1ns/100ps
`default_nettype none

module pit_timer #(
  parameter int RES   = 8,
  parameter int PHASE = 16
) (
  input  logic clk,
  input  logic arst_n_i,
  output logic tick_o
);

  localparam logic [RES:0] STEP = (RES + 1)'(PHASE);

  logic [RES-1:0] acc;
  logic [RES:0]   sum;

  // Extra top bit catches the carry out of the accumulator
  assign sum = {1'b0, acc} + STEP;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acc    <= '0;
      tick_o <= 1'b0;
    end else begin
      acc    <= sum[RES-1:0];
      // One-cycle pulse per wrap
      tick_o <= sum[RES];
    end
  end

endmodule

`default_nettype wire

// File: hdl/ram_slave.sv
// Word RAM, addresses above 2**ADR_W words wrap; master must drop stb after ack for a new access
`timescale 1ns/100ps
`default_nettype none

module ram_slave #(
  parameter int ADR_W = 10
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  soc_pkg::bus_dat_t mem [2**ADR_W];
  soc_pkg::bus_dat_t rd_q;
  logic [ADR_W-1:0]  wadr;
  logic              ack_q;
  logic              access;

  assign wadr = req_i.adr[ADR_W:1];

  // First strobed cycle only, the ack cycle itself is ignored
  assign access = req_i.stb & req_i.cyc & ~ack_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Array and read data
  always_ff @(posedge clk) begin
    if (access && req_i.we) begin
      if (req_i.sel[0]) begin
        mem[wadr][7:0] <= req_i.dat[7:0];
      end
      if (req_i.sel[1]) begin
        mem[wadr][15:8] <= req_i.dat[15:8];
      end
    end
    rd_q <= mem[wadr];
  end

  assign rsp_o.dat = rd_q;
  assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

// File: hdl/soc_core.sv
// Single clock domain, one bus master; irq_i lines are edge-triggered and must be synchronous to clk
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module soc_core (
  input  logic              clk,
  input  logic              arst_n_i,
  input  soc_pkg::bus_req_t bus_i,
  output soc_pkg::bus_rsp_t bus_o,
  input  logic              inta_i,
  output logic              intr_o,
  input  logic [7:1]        irq_i,
  input  logic [7:0]        sw_i,
  output soc_pkg::bus_dat_t led_o
);

  soc_pkg::bus_req_t mem_req;
  soc_pkg::bus_rsp_t mem_rsp;
  soc_pkg::irq_vec_t intv;
  soc_pkg::iid_t     iid;
  logic              tick;

  // Timer owns the top-priority line 0
  assign intv = {irq_i, tick};

  io_decoder u_io_decoder (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .bus_i     (bus_i),
    .bus_o     (bus_o),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp),
    .inta_i    (inta_i),
    .iid_i     (iid),
    .sw_i      (sw_i),
    .led_o     (led_o)
  );

  ram_slave #(
    .ADR_W (`SOC_RAM_AW)
  ) u_ram (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .req_i    (mem_req),
    .rsp_o    (mem_rsp)
  );

  pit_timer #(
    .RES   (`SOC_TIMER_RES),
    .PHASE (`SOC_TIMER_PHASE)
  ) u_timer (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .tick_o   (tick)
  );

  pic_simple u_pic (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .intv_i   (intv),
    .inta_i   (inta_i),
    .intr_o   (intr_o),
    .iid_o    (iid)
  );

endmodule

`default_nettype wire

// File: tests/soc_core_props.sv
// Assumes one master that holds its request until ack; checks run only outside reset
`timescale 1ns/100ps
`default_nettype none

module soc_core_props (
  input logic              clk,
  input logic              arst_n_i,
  input soc_pkg::bus_req_t bus_i,
  input soc_pkg::bus_rsp_t bus_rsp_i,
  input soc_pkg::bus_req_t mem_req_i,
  input soc_pkg::bus_rsp_t mem_rsp_i,
  input logic              inta_i,
  input logic              intr_i,
  input soc_pkg::bus_dat_t led_i
);

  int unsigned fail_count = 0;

  // RAM answers in the cycle after its first strobe
  ram_ack_next: assert property (@(posedge clk) disable iff (!arst_n_i)
      mem_req_i.stb && mem_req_i.cyc && !mem_rsp_i.ack |=> mem_rsp_i.ack)
    else begin
      fail_count++;
      $error("RAM ack did not follow its strobe by one cycle");
    end

  // I/O and vector cycles
  io_ack_now: assert property (@(posedge clk) disable iff (!arst_n_i)
      bus_i.stb && bus_i.cyc && (bus_i.tga || inta_i) |-> bus_rsp_i.ack)
    else begin
      fail_count++;
      $error("I/O ack missing in the strobe cycle");
    end

  ack_needs_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
      bus_rsp_i.ack |-> bus_i.stb && bus_i.cyc)
    else begin
      fail_count++;
      $error("ack seen without stb and cyc");
    end

  reset_values: assert property (@(posedge clk)
      $rose(arst_n_i) |-> led_i == '0 && !intr_i)
    else begin
      fail_count++;
      $error("led_o or intr_o not zero after reset");
    end

endmodule

bind soc_core soc_core_props u_props (
  .clk       (clk),
  .arst_n_i  (arst_n_i),
  .bus_i     (bus_i),
  .bus_rsp_i (bus_o),
  .mem_req_i (mem_req),
  .mem_rsp_i (mem_rsp),
  .inta_i    (inta_i),
  .intr_i    (intr_o),
  .led_i     (led_o)
);

`default_nettype wire

// File: tests/soc_core_tb.sv
// Single bus master for soc_core; expected values and timing assume the default soc_cfg.svh
`timescale 1ns/100ps
`default_nettype none

`include "soc_cfg.svh"

module soc_core_tb;

  // Six tests of at most about 400 cycles each, plus margin
  localparam int MAX_CYCLES = 3000;

  logic              clk = 1'b0;
  logic              arst_n_i = 1'b0;
  logic              inta = 1'b0;
  logic              intr;
  logic [7:1]        irq = '0;
  logic [7:0]        sw = 8'h00;
  soc_pkg::bus_req_t req = '0;
  soc_pkg::bus_rsp_t rsp;
  soc_pkg::bus_dat_t led;
  soc_pkg::bus_dat_t led_exp = '0;
  soc_pkg::bus_dat_t model [2**`SOC_RAM_AW];
  soc_pkg::bus_adr_t adrs [$];
  int unsigned       seed = 33488;
  int                cycles = 0;
  int                test_errors = 0;
  int                total_errors = 0;
  int                tests_failed = 0;

  soc_core UUT (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .bus_i    (req),
    .bus_o    (rsp),
    .inta_i   (inta),
    .intr_o   (intr),
    .irq_i    (irq),
    .sw_i     (sw),
    .led_o    (led)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [15:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[30:15];
  endfunction

  // Byte lanes of a write replace only the selected bytes
  function automatic soc_pkg::bus_dat_t merge_lanes(soc_pkg::bus_dat_t old,
      soc_pkg::bus_dat_t wdat, soc_pkg::bus_sel_t sel);
    return {sel[1] ? wdat[15:8] : old[15:8], sel[0] ? wdat[7:0] : old[7:0]};
  endfunction

  task automatic check_value(string what, logic [15:0] got, logic [15:0] exp);
    assert (got === exp) else begin
      test_errors++;
      $display("CHECK FAILED at %0d ns: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  // One bus cycle; on a read, dat is the expected data
  task automatic bus_cycle(string what, soc_pkg::bus_adr_t adr, logic tga, logic we,
      soc_pkg::bus_sel_t sel, soc_pkg::bus_dat_t dat, logic ack_int);
    int lat;
    @(negedge clk);
    req = '{adr: adr, dat: dat, we: we, tga: tga, sel: sel, stb: 1'b1, cyc: 1'b1};
    inta = ack_int;
    lat = 0;
    #1;
    while (!rsp.ack) begin
      @(negedge clk);
      #1;
      lat++;
    end
    // I/O and vector cycles answer at once, the RAM one cycle later
    check_value({what, " ack latency"}, 16'(lat), (tga || ack_int) ? 16'd0 : 16'd1);
    if (!we) begin
      check_value(what, rsp.dat, dat);
    end
    @(negedge clk);
    req.stb = 1'b0;
    req.cyc = 1'b0;
    inta = 1'b0;
  endtask

  task automatic mem_write(soc_pkg::bus_adr_t adr, soc_pkg::bus_sel_t sel,
      soc_pkg::bus_dat_t dat);
    bus_cycle("RAM write", adr, 1'b0, 1'b1, sel, dat, 1'b0);
    model[adr[`SOC_RAM_AW:1]] = merge_lanes(model[adr[`SOC_RAM_AW:1]], dat, sel);
  endtask

  task automatic vector_check(soc_pkg::iid_t iid);
    bus_cycle("vector", '0, 1'b0, 1'b0, 2'b11, {8'h00, `SOC_VEC_BASE + 8'(iid)}, 1'b1);
  endtask

  // Empties the controller, then serves the next tick right after it lands
  task automatic serve_fresh_tick();
    while (intr) begin
      // Write flag skips the data compare for vectors of unknown lines
      bus_cycle("drain", '0, 1'b0, 1'b1, 2'b11, 16'h0000, 1'b1);
    end
    while (!intr) begin
      @(negedge clk);
    end
    vector_check(3'd0);
  endtask

  task automatic report_test(string name);
    if (test_errors == 0) begin
      $display("PASS  %s", name);
    end else begin
      $display("FAIL  %s, %0d errors", name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  initial begin
    soc_pkg::bus_adr_t a;
    soc_pkg::bus_dat_t d;
    int n;
    repeat (4) @(negedge clk);
    arst_n_i = 1'b1;

    // Full-word writes, every fourth address then gets a single-lane update
    for (int i = 0; i < 32; i++) begin
      a = {3'(lcg_next()), lcg_next()};
      mem_write(a, 2'b11, lcg_next());
      if (i % 4 == 0) begin
        mem_write(a, (i % 8 == 0) ? 2'b01 : 2'b10, lcg_next());
      end
      adrs.push_back(a);
    end
    foreach (adrs[k]) begin
      bus_cycle("RAM read", adrs[k], 1'b0, 1'b0, 2'b11, model[adrs[k][`SOC_RAM_AW:1]], 1'b0);
    end
    report_test("1 RAM write and read-back");

    for (int s = 0; s < 4; s++) begin
      d = lcg_next();
      a = {4'h0, `SOC_IO_LED_PAGE, 7'(lcg_next())};
      bus_cycle("LED write", a, 1'b1, 1'b1, 2'(s), d, 1'b0);
      led_exp = merge_lanes(led_exp, d, 2'(s));
      check_value("led_o", led, led_exp);
    end
    // Neighbouring page
    bus_cycle("I/O write", {4'h0, 8'hF2, 7'h00}, 1'b1, 1'b1, 2'b11, ~led_exp, 1'b0);
    check_value("led_o", led, led_exp);
    report_test("2 LED port");

    sw = 8'(lcg_next());
    bus_cycle("switch", {4'h0, `SOC_IO_SW_ADR}, 1'b1, 1'b0, 2'b11, {8'h00, sw}, 1'b0);
    bus_cycle("status", {4'h0, `SOC_IO_STAT_ADR}, 1'b1, 1'b0, 2'b11, `SOC_STAT_WORD, 1'b0);
    bus_cycle("unmapped", 19'h00200, 1'b1, 1'b0, 2'b11, 16'hFFFF, 1'b0);
    report_test("3 fixed I/O reads");

    serve_fresh_tick();
    check_value("intr_o after ack", 16'(intr), 16'd0);
    n = 0;
    while (!intr) begin
      @(negedge clk);
      n++;
    end
    check_value("tick within one period", 16'(n <= 16), 16'd1);
    report_test("4 timer interrupt");

    serve_fresh_tick();
    irq[2] = 1'b1;
    irq[5] = 1'b1;
    @(negedge clk);
    irq = '0;
    vector_check(3'd2);
    vector_check(3'd5);
    check_value("intr_o after both", 16'(intr), 16'd0);
    report_test("5 interrupt priority");

    for (int i = 0; i < 24; i++) begin
      d = lcg_next();
      if (i % 2 == 1) begin
        bus_cycle("status", {4'h0, `SOC_IO_STAT_ADR}, 1'b1, 1'b0, 2'b11, `SOC_STAT_WORD, 1'b0);
      end else if (d[0]) begin
        mem_write(adrs[d[5:1]], d[7:6], lcg_next());
      end else begin
        a = adrs[d[5:1]];
        bus_cycle("RAM read", a, 1'b0, 1'b0, 2'b11, model[a[`SOC_RAM_AW:1]], 1'b0);
      end
      repeat (d[9:8]) @(negedge clk);
    end
    report_test("6 mixed back-to-back traffic");

    $display("Tests run 6, failed %0d, check errors %0d, property failures %0d",
             tests_failed, total_errors, UUT.u_props.fail_count);
    if (tests_failed == 0 && UUT.u_props.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
